//--- ppu_pkg.sv
package ppu_pkg;

   //////////////////////////////////////////////////
   // Timing constants
   //////////////////////////////////////////////////

   // System clocks per LCD dot
   localparam int dot_clocks      = 8;
   localparam int dots_per_line   = 456;
   localparam int lines_per_frame = 154;
   // First V-Blank line
   localparam int visible_lines   = 144;
   // Mode 2 length in dots
   localparam int oam_dots        = 80;
   // Mode 3 length in dots
   localparam int xfer_dots       = 172;
   localparam int screen_width    = 160;

   // VRAM byte address, 8 KiB
   typedef logic [12:0] vram_addr_t;

   //////////////////////////////////////////////////
   // CPU address map
   //////////////////////////////////////////////////

   localparam logic [15:0] vram_base = 16'h8000;
   localparam logic [15:0] vram_end  = 16'hA000;
   localparam logic [15:0] lcdc_addr = 16'hFF40;
   localparam logic [15:0] stat_addr = 16'hFF41;
   localparam logic [15:0] scy_addr  = 16'hFF42;
   localparam logic [15:0] scx_addr  = 16'hFF43;
   localparam logic [15:0] ly_addr   = 16'hFF44;
   localparam logic [15:0] lyc_addr  = 16'hFF45;
   localparam logic [15:0] bgp_addr  = 16'hFF47;

   // Offsets inside VRAM
   localparam vram_addr_t map_lo_off       = 13'h1800;
   localparam vram_addr_t map_hi_off       = 13'h1C00;
   // Tile 0 in signed tile mode
   localparam vram_addr_t tiles_signed_off = 13'h1000;

   // Identity palette after reset
   localparam logic [7:0] bgp_init = 8'hE4;

   // STAT mode field encoding
   typedef enum logic [1:0] {
      hblank     = 2'd0,
      vblank     = 2'd1,
      oam_search = 2'd2,
      xfer       = 2'd3
   } ppu_mode_t;

   // LCDC flags, bit 7 down to bit 0
   typedef struct packed {
      logic display_on;
      logic window_map;
      logic window_on;
      logic tile_data_sel;
      logic bg_map_sel;
      logic obj_size;
      logic window_prio;
      logic bg_on;
   } lcdc_bits_t;

   // CPU sees a byte, the blocks see flags
   typedef union packed {
      logic [7:0] raw;
      lcdc_bits_t bits;
   } lcdc_u;

   // One-cycle CPU request
   typedef struct packed {
      logic        strobe;
      logic        write;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } bus_req_t;

   // Pixel to the video converter
   typedef struct packed {
      logic       strobe;
      logic [7:0] line;
      logic [7:0] x;
      logic [1:0] shade;
   } pixel_t;

   // Render controls from the register block
   typedef struct packed {
      logic [7:0] scy;
      logic [7:0] scx;
      logic [7:0] bgp;
      lcdc_u      lcdc;
   } view_t;

endpackage

//--- ppu_mmio.sv
`timescale 1ns/1ps

module ppu_mmio (
   input  logic                  I_CLOCK,
   input  logic                  I_RESET,
   input  ppu_pkg::bus_req_t     req,
   input  ppu_pkg::ppu_mode_t    mode,
   input  logic [7:0]            line,
   input  logic [7:0]            vram_rdata,
   output logic [7:0]            rdata,
   output ppu_pkg::vram_addr_t   vram_addr,
   output logic                  vram_we,
   output logic [7:0]            vram_wdata,
   output ppu_pkg::view_t        view,
   output logic [7:0]            lyc,
   output logic [3:0]            stat_sel
);

   logic       wr_strobe;
   logic       rd_strobe;
   logic       is_vram;
   logic       vram_rd_ok;
   logic       rd_vram;
   logic [7:0] rd_hold;
   logic [7:0] reg_rdata;

   // Access type and region
   assign wr_strobe = req.strobe && req.write;
   assign rd_strobe = req.strobe && !req.write;
   assign is_vram   = (req.addr >= ppu_pkg::vram_base) && (req.addr < ppu_pkg::vram_end);

   //////////////////////////////////////////////////
   // VRAM port A
   //////////////////////////////////////////////////

   // CPU owns port A, renderer uses port B
   assign vram_addr  = ppu_pkg::vram_addr_t'(req.addr - ppu_pkg::vram_base);
   assign vram_wdata = req.wdata;
   // Locked while the renderer fetches
   assign vram_we    = wr_strobe && is_vram && (mode != ppu_pkg::xfer);
   assign vram_rd_ok = rd_strobe && is_vram && (mode != ppu_pkg::xfer);

   //////////////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////////////

   always_ff @(posedge I_CLOCK) begin
      if (I_RESET) begin
         view.lcdc.raw <= '0;
         view.scy      <= '0;
         view.scx      <= '0;
         view.bgp      <= ppu_pkg::bgp_init;
         lyc           <= '0;
         stat_sel      <= '0;
      end else if (wr_strobe) begin
         case (req.addr)
            ppu_pkg::lcdc_addr: view.lcdc.raw <= req.wdata;
            // Only the four interrupt selects are writable
            ppu_pkg::stat_addr: stat_sel <= req.wdata[6:3];
            ppu_pkg::scy_addr:  view.scy <= req.wdata;
            ppu_pkg::scx_addr:  view.scx <= req.wdata;
            ppu_pkg::lyc_addr:  lyc <= req.wdata;
            ppu_pkg::bgp_addr:  view.bgp <= req.wdata;
            // LY is read only
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////

   // Register and unmapped reads
   always_comb begin
      case (req.addr)
         ppu_pkg::lcdc_addr: reg_rdata = view.lcdc.raw;
         // Bit 7 reads 0, bit 2 is LY == LYC
         ppu_pkg::stat_addr: reg_rdata = {1'b0, stat_sel, line == lyc, mode};
         ppu_pkg::scy_addr:  reg_rdata = view.scy;
         ppu_pkg::scx_addr:  reg_rdata = view.scx;
         ppu_pkg::ly_addr:   reg_rdata = line;
         ppu_pkg::lyc_addr:  reg_rdata = lyc;
         ppu_pkg::bgp_addr:  reg_rdata = view.bgp;
         // Also covers locked VRAM
         default:            reg_rdata = 8'hFF;
      endcase
   end

   // Register data waits one cycle to line up with VRAM
   always_ff @(posedge I_CLOCK) begin
      if (I_RESET) begin
         rd_vram <= 1'b0;
         rd_hold <= 8'hFF;
      end else begin
         rd_vram <= vram_rd_ok;
         // Keep VRAM byte once the port moves on
         if (rd_vram) begin
            rd_hold <= vram_rdata;
         end
         // A new read overrides the capture
         if (rd_strobe) begin
            rd_hold <= reg_rdata;
         end
      end
   end

   // VRAM byte is live for one cycle, then held
   assign rdata = rd_vram ? vram_rdata : rd_hold;

endmodule

//--- ppu_timing.sv
`timescale 1ns/1ps

module ppu_timing (
   input  logic               I_CLOCK,
   input  logic               I_RESET,
   input  logic               display_on,
   input  logic [7:0]         lyc,
   input  logic [3:0]         stat_sel,
   input  logic               ack_vblank,
   input  logic               ack_stat,
   output logic [7:0]         line,
   output ppu_pkg::ppu_mode_t mode,
   output logic               irq_vblank,
   output logic               irq_stat
);

   localparam int div_w = $clog2(ppu_pkg::dot_clocks);

   logic [div_w-1:0]   div;
   logic [8:0]         dot;
   logic               tick;
   logic               mode_enter;
   logic               vblank_event;
   logic               stat_event;
   ppu_pkg::ppu_mode_t prev_mode;

   //////////////////////////////////////////////////
   // Dot and line counters
   //////////////////////////////////////////////////

   // One dot every dot_clocks clocks
   assign tick = (div == div_w'(ppu_pkg::dot_clocks - 1));

   always_ff @(posedge I_CLOCK) begin
      // Display off parks everything at dot 0 of line 0
      if (I_RESET || !display_on) begin
         div  <= '0;
         dot  <= '0;
         line <= '0;
      end else if (tick) begin
         div <= '0;
         if (dot == 9'(ppu_pkg::dots_per_line - 1)) begin
            dot <= '0;
            // Frame wrap after the last V-Blank line
            if (line == 8'(ppu_pkg::lines_per_frame - 1)) begin
               line <= '0;
            end else begin
               line <= line + 8'd1;
            end
         end else begin
            dot <= dot + 9'd1;
         end
      end else begin
         div <= div + 1'b1;
      end
   end

   // Mode straight from the counters
   always_comb begin
      if (!display_on) begin
         mode = ppu_pkg::hblank;
      end else if (line >= 8'(ppu_pkg::visible_lines)) begin
         mode = ppu_pkg::vblank;
      end else if (dot < 9'(ppu_pkg::oam_dots)) begin
         mode = ppu_pkg::oam_search;
      end else if (dot < 9'(ppu_pkg::oam_dots + ppu_pkg::xfer_dots)) begin
         mode = ppu_pkg::xfer;
      end else begin
         mode = ppu_pkg::hblank;
      end
   end

   //////////////////////////////////////////////////
   // Interrupts
   //////////////////////////////////////////////////

   assign mode_enter   = display_on && (mode != prev_mode);
   // Mode turns to vblank in the same cycle line hits 144
   assign vblank_event = mode_enter && (mode == ppu_pkg::vblank);

   // stat_sel is STAT bits 6 to 3
   assign stat_event = (mode_enter && (mode == ppu_pkg::hblank) && stat_sel[0]) ||
                       (mode_enter && (mode == ppu_pkg::vblank) && stat_sel[1]) ||
                       (mode_enter && (mode == ppu_pkg::oam_search) && stat_sel[2]) ||
                       (display_on && (dot == '0) && (line == lyc) && stat_sel[3]);

   always_ff @(posedge I_CLOCK) begin
      if (I_RESET) begin
         prev_mode  <= ppu_pkg::hblank;
         irq_vblank <= 1'b0;
         irq_stat   <= 1'b0;
      end else begin
         prev_mode <= mode;
         // Set beats acknowledge
         if (vblank_event) begin
            irq_vblank <= 1'b1;
         end else if (ack_vblank) begin
            irq_vblank <= 1'b0;
         end
         if (stat_event) begin
            irq_stat <= 1'b1;
         end else if (ack_stat) begin
            irq_stat <= 1'b0;
         end
      end
   end

endmodule

//--- ppu_vram.sv
`timescale 1ns/1ps

module ppu_vram (
   input  logic                I_CLOCK,
   // CPU side
   input  ppu_pkg::vram_addr_t a_addr,
   input  logic                a_we,
   input  logic [7:0]          a_wdata,
   output logic [7:0]          a_rdata,
   // Renderer side
   input  ppu_pkg::vram_addr_t b_addr,
   output logic [7:0]          b_rdata
);

   // 8 KiB, tile data then two tile maps
   localparam int depth = int'(ppu_pkg::vram_end - ppu_pkg::vram_base);

   logic [7:0] mem [0:depth-1];

   // Port A, write first then read old data
   always_ff @(posedge I_CLOCK) begin
      if (a_we) begin
         mem[a_addr] <= a_wdata;
      end
      a_rdata <= mem[a_addr];
   end

   // Port B, read only
   always_ff @(posedge I_CLOCK) begin
      b_rdata <= mem[b_addr];
   end

endmodule

//--- ppu_bg_render.sv
`timescale 1ns/1ps

module ppu_bg_render (
   input  logic                I_CLOCK,
   input  logic                I_RESET,
   input  ppu_pkg::ppu_mode_t  mode,
   input  logic [7:0]          line,
   input  ppu_pkg::view_t      view,
   output ppu_pkg::vram_addr_t vram_addr,
   input  logic [7:0]          vram_rdata,
   output ppu_pkg::pixel_t     pixel
);

   // One tile fetch, then pixels until the tile edge
   typedef enum logic [2:0] {
      st_idle,
      st_map,
      st_map_wait,
      st_lo_addr,
      st_hi_addr,
      st_lo_data,
      st_hi_data,
      st_pixel
   } state_t;

   state_t              state;
   ppu_pkg::ppu_mode_t  prev_mode;
   logic                start;
   logic [7:0]          bg_y;
   logic [7:0]          x;
   logic [7:0]          bg_x;
   logic [2:0]          fine;
   logic [7:0]          lo_q;
   logic [7:0]          hi_q;
   logic [1:0]          color_idx;
   logic [1:0]          shade;
   ppu_pkg::vram_addr_t map_addr;
   ppu_pkg::vram_addr_t tile_addr;

   //////////////////////////////////////////////////
   // Address and pixel math
   //////////////////////////////////////////////////

   // Start on mode 3 entry of a visible line
   assign start = (mode == ppu_pkg::xfer) && (prev_mode != ppu_pkg::xfer) &&
                  (line < 8'(ppu_pkg::visible_lines));

   // Background x wraps at 256
   assign bg_x = view.scx + x;
   assign fine = bg_x[2:0];

   // 32x32 map, row then column
   assign map_addr = (view.lcdc.bits.bg_map_sel ? ppu_pkg::map_hi_off : ppu_pkg::map_lo_off) +
                     {3'b000, bg_y[7:3], bg_x[7:3]};

   // Tile id arrives on vram_rdata, 16 bytes per tile, 2 per row
   always_comb begin
      if (view.lcdc.bits.tile_data_sel) begin
         tile_addr = {1'b0, vram_rdata, bg_y[2:0], 1'b0};
      end else begin
         // Signed id around the middle of tile data
         tile_addr = ppu_pkg::tiles_signed_off + {vram_rdata[7], vram_rdata, bg_y[2:0], 1'b0};
      end
   end

   // Leftmost pixel is bit 7, high plane is the upper bit
   assign color_idx = view.lcdc.bits.bg_on ? {hi_q[3'd7 - fine], lo_q[3'd7 - fine]} : 2'b00;
   assign shade     = view.bgp[{color_idx, 1'b0} +: 2];

   //////////////////////////////////////////////////
   // Fetch FSM
   //////////////////////////////////////////////////

   always_ff @(posedge I_CLOCK) begin
      if (I_RESET) begin
         state        <= st_idle;
         prev_mode    <= ppu_pkg::hblank;
         vram_addr    <= '0;
         pixel.strobe <= 1'b0;
      end else begin
         prev_mode    <= mode;
         pixel.strobe <= 1'b0;
         case (state)
            st_idle: begin
               if (start) begin
                  bg_y  <= view.scy + line;
                  x     <= '0;
                  state <= st_map;
               end
            end
            // Map entry for the current tile column
            st_map: begin
               vram_addr <= map_addr;
               state     <= st_map_wait;
            end
            st_map_wait: begin
               state <= st_lo_addr;
            end
            // Tile id is on the read port now
            st_lo_addr: begin
               vram_addr <= tile_addr;
               state     <= st_hi_addr;
            end
            // High plane follows the low plane
            st_hi_addr: begin
               vram_addr <= {vram_addr[12:1], 1'b1};
               state     <= st_lo_data;
            end
            st_lo_data: begin
               lo_q  <= vram_rdata;
               state <= st_hi_data;
            end
            st_hi_data: begin
               hi_q  <= vram_rdata;
               state <= st_pixel;
            end
            // One strobe per cycle
            st_pixel: begin
               pixel.strobe <= 1'b1;
               pixel.line   <= line;
               pixel.x      <= x;
               pixel.shade  <= shade;
               x            <= x + 8'd1;
               if (x == 8'(ppu_pkg::screen_width - 1)) begin
                  state <= st_idle;
               end else if (fine == 3'd7) begin
                  // Next pixel lies in a new tile
                  state <= st_map;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

//--- ppu_top.sv
`timescale 1ns/1ps

module ppu_top (
   input  logic               I_CLOCK,
   input  logic               I_RESET,
   // CPU bus
   input  ppu_pkg::bus_req_t  req,
   output logic [7:0]         rdata,
   // Interrupts
   input  logic               ack_vblank,
   input  logic               ack_stat,
   output logic               irq_vblank,
   output logic               irq_stat,
   // Status and video converter
   output logic [7:0]         line,
   output ppu_pkg::ppu_mode_t mode,
   output ppu_pkg::pixel_t    pixel
);

   ppu_pkg::view_t      view;
   logic [7:0]          lyc;
   logic [3:0]          stat_sel;
   ppu_pkg::vram_addr_t cpu_vram_addr;
   logic                cpu_vram_we;
   logic [7:0]          cpu_vram_wdata;
   logic [7:0]          cpu_vram_rdata;
   ppu_pkg::vram_addr_t bg_vram_addr;
   logic [7:0]          bg_vram_rdata;

   // Registers and bus decode
   ppu_mmio mmio_i (
      .I_CLOCK    (I_CLOCK),
      .I_RESET    (I_RESET),
      .req        (req),
      .mode       (mode),
      .line       (line),
      .vram_rdata (cpu_vram_rdata),
      .rdata      (rdata),
      .vram_addr  (cpu_vram_addr),
      .vram_we    (cpu_vram_we),
      .vram_wdata (cpu_vram_wdata),
      .view       (view),
      .lyc        (lyc),
      .stat_sel   (stat_sel)
   );

   // Dot, line, mode and IRQs
   ppu_timing timing_i (
      .I_CLOCK    (I_CLOCK),
      .I_RESET    (I_RESET),
      .display_on (view.lcdc.bits.display_on),
      .lyc        (lyc),
      .stat_sel   (stat_sel),
      .ack_vblank (ack_vblank),
      .ack_stat   (ack_stat),
      .line       (line),
      .mode       (mode),
      .irq_vblank (irq_vblank),
      .irq_stat   (irq_stat)
   );

   ppu_vram vram_i (
      .I_CLOCK (I_CLOCK),
      .a_addr  (cpu_vram_addr),
      .a_we    (cpu_vram_we),
      .a_wdata (cpu_vram_wdata),
      .a_rdata (cpu_vram_rdata),
      .b_addr  (bg_vram_addr),
      .b_rdata (bg_vram_rdata)
   );

   // Background pixels during mode 3
   ppu_bg_render render_i (
      .I_CLOCK    (I_CLOCK),
      .I_RESET    (I_RESET),
      .mode       (mode),
      .line       (line),
      .view       (view),
      .vram_addr  (bg_vram_addr),
      .vram_rdata (bg_vram_rdata),
      .pixel      (pixel)
   );

endmodule

//--- ppu_tb_tasks.svh
`ifndef PPU_TB_TASKS_SVH
`define PPU_TB_TASKS_SVH

//////////////////////////////////////////////////
// CPU bus
//////////////////////////////////////////////////

// One strobe cycle, called on a falling edge
task automatic write_bus(input logic [15:0] addr, input logic [7:0] data);
   req.strobe = 1'b1;
   req.write  = 1'b1;
   req.addr   = addr;
   req.wdata  = data;
   @(negedge I_CLOCK);
   req = '0;
endtask

// Read data is valid one clock after the strobe
task automatic read_expect(input string name, input logic [15:0] addr, input logic [7:0] exp);
   req.strobe = 1'b1;
   req.write  = 1'b0;
   req.addr   = addr;
   req.wdata  = '0;
   @(negedge I_CLOCK);
   req = '0;
   check_byte(name, rdata, exp);
endtask

// Single-cycle acknowledge pulses
task automatic acknowledge(input logic vbl, input logic stat);
   ack_vblank = vbl;
   ack_stat   = stat;
   @(negedge I_CLOCK);
   ack_vblank = 1'b0;
   ack_stat   = 1'b0;
endtask

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
   if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
   end
endtask

task automatic check_mode(input string name, input ppu_pkg::ppu_mode_t got,
                          input ppu_pkg::ppu_mode_t exp);
   if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
   end
endtask

task automatic check_pixel(input string name, input ppu_pkg::pixel_t got,
                           input ppu_pkg::pixel_t exp);
   if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
   end
endtask

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Mode from dot and line
function automatic ppu_pkg::ppu_mode_t expected_mode(input int dt, input int ln);
   if (ln >= ppu_pkg::visible_lines) return ppu_pkg::vblank;
   if (dt < ppu_pkg::oam_dots) return ppu_pkg::oam_search;
   if (dt < ppu_pkg::oam_dots + ppu_pkg::xfer_dots) return ppu_pkg::xfer;
   return ppu_pkg::hblank;
endfunction

// Background pixel from the VRAM and register copies
function automatic ppu_pkg::pixel_t expected_pixel(input logic [7:0] ln, input logic [7:0] px);
   logic [7:0]      by;
   logic [7:0]      bx;
   logic [7:0]      lo;
   logic [7:0]      hi;
   logic [1:0]      ci;
   int              map_idx;
   int              tid;
   int              row;
   int              bit_pos;
   ppu_pkg::pixel_t p;
   by = scy_m + ln;
   bx = scx_m + px;
   // 32 entries per map row
   map_idx = lcdc_m.bits.bg_map_sel ? int'(ppu_pkg::map_hi_off) : int'(ppu_pkg::map_lo_off);
   map_idx = map_idx + int'(by[7:3]) * 32 + int'(bx[7:3]);
   if (lcdc_m.bits.tile_data_sel) begin
      tid = int'(vram_m[map_idx]);
      row = tid * 16;
   end else begin
      // Tile id taken as -128 to 127
      tid = int'($signed(vram_m[map_idx]));
      row = int'(ppu_pkg::tiles_signed_off) + tid * 16;
   end
   row = (row + int'(by[2:0]) * 2) & 'h1FFF;
   lo = vram_m[row];
   hi = vram_m[row + 1];
   bit_pos = 7 - int'(bx[2:0]);
   ci = {hi[bit_pos], lo[bit_pos]};
   if (!lcdc_m.bits.bg_on) begin
      ci = 2'b00;
   end
   p.strobe = 1'b1;
   p.line   = ln;
   p.x      = px;
   p.shade  = bgp_m[2 * ci +: 2];
   return p;
endfunction

`endif

//--- ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb;

   localparam int line_clocks  = ppu_pkg::dot_clocks * ppu_pkg::dots_per_line;
   localparam int frame_clocks = line_clocks * ppu_pkg::lines_per_frame;
   // Three frames of timing plus bus traffic
   localparam int max_cycles   = 3 * frame_clocks + 20000;

   logic               I_CLOCK;
   logic               I_RESET;
   ppu_pkg::bus_req_t  req;
   logic [7:0]         rdata;
   logic               ack_vblank;
   logic               ack_stat;
   logic               irq_vblank;
   logic               irq_stat;
   logic [7:0]         line;
   ppu_pkg::ppu_mode_t mode;
   ppu_pkg::pixel_t    pixel;

   // Copies of everything written over the bus
   logic [7:0]         vram_m [0:8191];
   logic [7:0]         scx_m;
   logic [7:0]         scy_m;
   logic [7:0]         bgp_m;
   logic [7:0]         lyc_m;
   ppu_pkg::lcdc_u     lcdc_m;
   int                 cycles;

   ppu_top dut_i (
      .I_CLOCK    (I_CLOCK),
      .I_RESET    (I_RESET),
      .req        (req),
      .rdata      (rdata),
      .ack_vblank (ack_vblank),
      .ack_stat   (ack_stat),
      .irq_vblank (irq_vblank),
      .irq_stat   (irq_stat),
      .line       (line),
      .mode       (mode),
      .pixel      (pixel)
   );

   // 40 ns clock
   initial begin
      I_CLOCK = 1'b0;
      forever #20 I_CLOCK = ~I_CLOCK;
   end

   // Run limit
   always @(posedge I_CLOCK) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout, run did not finish within %0d clock cycles", max_cycles);
         stop_on_error();
      end
   end

   task automatic stop_on_error();
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   `include "ppu_tb_tasks.svh"

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic register_test();
      logic [7:0] v;
      // Reset values
      check_byte("rdata", rdata, 8'hFF);
      read_expect("LCDC", ppu_pkg::lcdc_addr, 8'h00);
      read_expect("BGP", ppu_pkg::bgp_addr, 8'hE4);
      read_expect("SCY", ppu_pkg::scy_addr, 8'h00);
      read_expect("LYC", ppu_pkg::lyc_addr, 8'h00);
      read_expect("STAT", ppu_pkg::stat_addr, 8'h04);
      scy_m = 8'($urandom);
      scx_m = 8'($urandom);
      lyc_m = 8'($urandom);
      bgp_m = 8'($urandom);
      write_bus(ppu_pkg::scy_addr, scy_m);
      write_bus(ppu_pkg::scx_addr, scx_m);
      write_bus(ppu_pkg::lyc_addr, lyc_m);
      write_bus(ppu_pkg::bgp_addr, bgp_m);
      read_expect("SCY", ppu_pkg::scy_addr, scy_m);
      read_expect("SCX", ppu_pkg::scx_addr, scx_m);
      read_expect("LYC", ppu_pkg::lyc_addr, lyc_m);
      read_expect("BGP", ppu_pkg::bgp_addr, bgp_m);
      // LY is read only
      write_bus(ppu_pkg::ly_addr, 8'($urandom));
      read_expect("LY", ppu_pkg::ly_addr, 8'h00);
      // LY stays 0 while the display is off
      v = 8'($urandom);
      write_bus(ppu_pkg::stat_addr, v);
      read_expect("STAT", ppu_pkg::stat_addr, {1'b0, v[6:3], lyc_m == 8'h00, 2'b00});
      lyc_m = 8'h00;
      write_bus(ppu_pkg::lyc_addr, lyc_m);
      read_expect("STAT", ppu_pkg::stat_addr, {1'b0, v[6:3], 1'b1, 2'b00});
      // LCDC without the display bit
      v = 8'($urandom) & 8'h7F;
      write_bus(ppu_pkg::lcdc_addr, v);
      read_expect("LCDC", ppu_pkg::lcdc_addr, v);
      lcdc_m.raw = 8'h00;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
   endtask

   task automatic vram_test();
      ppu_pkg::vram_addr_t addrs [16];
      ppu_pkg::vram_addr_t a;
      logic [7:0]          d;
      for (int i = 0; i < 16; i++) begin
         a = ppu_pkg::vram_addr_t'($urandom);
         d = 8'($urandom);
         addrs[i]  = a;
         vram_m[a] = d;
         write_bus(ppu_pkg::vram_base + 16'(a), d);
      end
      for (int i = 0; i < 16; i++) begin
         read_expect("VRAM", ppu_pkg::vram_base + 16'(addrs[i]), vram_m[addrs[i]]);
      end
      lcdc_m.raw = 8'h91;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
      while (mode != ppu_pkg::xfer) @(negedge I_CLOCK);
      // Locked in mode 3 for reads and writes
      a = addrs[0];
      read_expect("VRAM locked", ppu_pkg::vram_base + 16'(a), 8'hFF);
      write_bus(ppu_pkg::vram_base + 16'(a), ~vram_m[a]);
      while (mode != ppu_pkg::hblank) @(negedge I_CLOCK);
      read_expect("VRAM after lock", ppu_pkg::vram_base + 16'(a), vram_m[a]);
      lcdc_m.raw = 8'h00;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
   endtask

   task automatic timing_test();
      int dots;
      int dt;
      int ln;
      lcdc_m.raw = 8'h91;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
      // Dot 0 of line 0 right after the enable
      for (int k = 0; k < frame_clocks + 3 * line_clocks + 100; k++) begin
         dots = k / ppu_pkg::dot_clocks;
         dt   = dots % ppu_pkg::dots_per_line;
         ln   = (dots / ppu_pkg::dots_per_line) % ppu_pkg::lines_per_frame;
         check_mode("mode", mode, expected_mode(dt, ln));
         check_byte("line", line, 8'(ln));
         @(negedge I_CLOCK);
      end
      lcdc_m.raw = 8'h00;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
      check_mode("mode", mode, ppu_pkg::hblank);
      // Counter clears one clock later
      @(negedge I_CLOCK);
      check_byte("line", line, 8'h00);
   endtask

   task automatic irq_test();
      acknowledge(1'b1, 1'b1);
      check_byte("irq_vblank", {7'd0, irq_vblank}, 8'h00);
      check_byte("irq_stat", {7'd0, irq_stat}, 8'h00);
      lyc_m = 8'd3 + 8'($urandom % 8);
      write_bus(ppu_pkg::lyc_addr, lyc_m);
      // HBlank and LYC enables
      write_bus(ppu_pkg::stat_addr, 8'h48);
      lcdc_m.raw = 8'h91;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
      // Flag follows the mode change by one clock
      while (mode != ppu_pkg::hblank) @(negedge I_CLOCK);
      check_byte("irq_stat", {7'd0, irq_stat}, 8'h00);
      @(negedge I_CLOCK);
      check_byte("irq_stat", {7'd0, irq_stat}, 8'h01);
      // Clear in the HBlank before line LYC
      while (!(line == lyc_m - 8'd1 && mode == ppu_pkg::hblank)) @(negedge I_CLOCK);
      @(negedge I_CLOCK);
      acknowledge(1'b0, 1'b1);
      check_byte("irq_stat", {7'd0, irq_stat}, 8'h00);
      while (line != lyc_m) @(negedge I_CLOCK);
      check_byte("irq_stat", {7'd0, irq_stat}, 8'h00);
      @(negedge I_CLOCK);
      check_byte("irq_stat", {7'd0, irq_stat}, 8'h01);
      // V-Blank holds until acknowledged
      while (line != 8'(ppu_pkg::visible_lines)) @(negedge I_CLOCK);
      check_byte("irq_vblank", {7'd0, irq_vblank}, 8'h00);
      repeat (64) begin
         @(negedge I_CLOCK);
         check_byte("irq_vblank", {7'd0, irq_vblank}, 8'h01);
      end
      acknowledge(1'b1, 1'b0);
      check_byte("irq_vblank", {7'd0, irq_vblank}, 8'h00);
      lcdc_m.raw = 8'h00;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
   endtask

   // Whole VRAM with tile data and both maps
   task automatic fill_vram();
      logic [7:0] d;
      for (int i = 0; i < 8192; i++) begin
         d = 8'($urandom);
         vram_m[i] = d;
         write_bus(ppu_pkg::vram_base + 16'(i), d);
      end
   endtask

   task automatic render_pass(input logic data_sel, input logic map_sel, input logic bg,
                              input int nlines);
      int count;
      scx_m = 8'($urandom);
      scy_m = 8'($urandom);
      bgp_m = 8'($urandom);
      write_bus(ppu_pkg::scx_addr, scx_m);
      write_bus(ppu_pkg::scy_addr, scy_m);
      write_bus(ppu_pkg::bgp_addr, bgp_m);
      lcdc_m.raw                = 8'h00;
      lcdc_m.bits.display_on    = 1'b1;
      lcdc_m.bits.tile_data_sel = data_sel;
      lcdc_m.bits.bg_map_sel    = map_sel;
      lcdc_m.bits.bg_on         = bg;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
      for (int ln = 0; ln < nlines; ln++) begin
         count = 0;
         while (line == 8'(ln)) begin
            if (pixel.strobe) begin
               check_pixel("pixel", pixel, expected_pixel(8'(ln), 8'(count)));
               count++;
            end
            @(negedge I_CLOCK);
         end
         if (count != ppu_pkg::screen_width) begin
            $display("Line %0d gave %0d pixel strobes instead of %0d", ln, count,
                     ppu_pkg::screen_width);
            stop_on_error();
         end
      end
      lcdc_m.raw = 8'h00;
      write_bus(ppu_pkg::lcdc_addr, lcdc_m.raw);
   endtask

   task automatic render_test();
      fill_vram();
      // Signed tiles and the high map
      render_pass(1'b0, 1'b1, 1'b1, 3);
      // Unsigned tiles and the low map
      render_pass(1'b1, 1'b0, 1'b1, 3);
      // Background off gives BGP bits 1 to 0 only
      render_pass(1'b1, 1'b0, 1'b0, 2);
   endtask

   //////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h63f3_674d));
      req        = '0;
      ack_vblank = 1'b0;
      ack_stat   = 1'b0;
      I_RESET    = 1'b1;
      lcdc_m     = '0;
      repeat (8) @(negedge I_CLOCK);
      I_RESET = 1'b0;
      register_test();
      vram_test();
      timing_test();
      irq_test();
      render_test();
      $display("Test OK");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
ppu_pkg.sv
ppu_mmio.sv
ppu_timing.sv
ppu_vram.sv
ppu_bg_render.sv
ppu_top.sv
ppu_tb.sv

//--- Bender.yml
package:
  name: ppu

sources:
  - ppu_pkg.sv
  - ppu_mmio.sv
  - ppu_timing.sv
  - ppu_vram.sv
  - ppu_bg_render.sv
  - ppu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - ppu_tb.sv
